// ==== Makefile ====
# Verilator build and run of the cache tag directory testbench
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -x "$(PASS_MSG)" $(LOG); then echo "TEST PASSED"; \
	else echo "TEST FAILED"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/cache_tb.sv ====
// Testbench of the 4-way set-associative tag directory
// A directed table runs first, then a random phase checked against a reference model
// Results are matched in request order as done pulses and set_valid follows one cycle later

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tb;
	import cache_addr_pkg::*;
	import cache_way_pkg::*;

	localparam int   TIMEOUT = 20;
	localparam logic REQ     = 1'b0;
	localparam logic FLUSH   = 1'b1;
	localparam logic MISS    = 1'b0;
	localparam logic HIT     = 1'b1;

	logic     clk;
	logic     rst_n;
	logic     req;
	address_t adr;
	logic     flush;
	logic     done;
	logic     hit;
	way_t     way;
	logic     set_valid;

	// Results still owed by the DUT with the oldest first
	logic exp_hit_q [$];
	way_t exp_way_q [$];
	logic exp_sv_q [$];

	// Cycle number in which each outstanding request was driven
	int exp_step_q [$];
	int step_no;

	// set_valid of a result is due one cycle after its done
	logic sv_due;
	logic sv_exp;
	int   stall;

	// Reference model of tags, valid bits and round-robin pointers
	tag_t      m_tag [`CACHE_LINES][`CACHE_WAYS];
	way_mask_t m_valid [`CACHE_LINES];
	way_t      m_ptr [`CACHE_LINES];

	logic [31:0] lfsr;

	// Directed table with one row per operation
	logic     tbl_flush [$];
	address_t tbl_adr [$];
	logic     tbl_hit [$];
	way_t     tbl_way [$];
	logic     tbl_sv [$];

	cache_dir_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.adr       (adr),
		.flush     (flush),
		.done      (done),
		.hit       (hit),
		.way       (way),
		.set_valid (set_valid)
	);

	always #10 clk = ~clk;

	// ============================================================
	// Checking
	// ============================================================

	task automatic report_failure(input string what);
		$display("%s at %0t", what, $time);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// One clock that drives 1 ns after the rising edge and looks at outputs on the falling edge
	// A request driven in one cycle owes its done two cycles later
	task automatic step_cycle(input logic do_req, input address_t a, input logic do_flush);
		logic eh;
		way_t ew;
		int   issued;
		step_no++;
		@(posedge clk);
		#1;
		req   = do_req;
		adr   = a;
		flush = do_flush;
		@(negedge clk);
		if (sv_due)
		begin
			check_value("set_valid", 32'(set_valid), 32'(sv_exp));
			sv_due = 1'b0;
		end
		if (done)
		begin
			if (exp_hit_q.size() == 0)
				report_failure("done pulsed with no request outstanding");
			else
			begin
				eh     = exp_hit_q.pop_front();
				ew     = exp_way_q.pop_front();
				issued = exp_step_q.pop_front();
				check_value("done latency", 32'(step_no - issued), 32'd2);
				check_value("hit", 32'(hit), 32'(eh));
				check_value("way", 32'(way), 32'(ew));
				sv_exp = exp_sv_q.pop_front();
				sv_due = 1'b1;
				stall  = 0;
			end
		end
		else if (exp_hit_q.size() != 0)
		begin
			stall++;
			if (stall > TIMEOUT)
				report_failure("timeout waiting for done");
		end
	endtask

	// Idle until every queued result and its set_valid has been seen
	task automatic drain_results();
		int n;
		n = 0;
		while (exp_hit_q.size() != 0 || sv_due)
		begin
			n++;
			if (n > TIMEOUT)
				report_failure("results did not drain");
			else
				step_cycle(1'b0, '0, 1'b0);
		end
	endtask

	// ============================================================
	// Stimulus helpers and reference model
	// ============================================================

	function automatic address_t make_adr(input tag_t t, input index_t s, input offset_t o);
		return {t, s, o};
	endfunction

	task automatic add_entry(input logic f, input tag_t t, input index_t s, input offset_t o,
		input logic h, input way_t w, input logic sv);
		tbl_flush.push_back(f);
		tbl_adr.push_back(make_adr(t, s, o));
		tbl_hit.push_back(h);
		tbl_way.push_back(w);
		tbl_sv.push_back(sv);
	endtask

	// Taps 32, 22, 2 and 1 with one step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Lookup with allocation on a miss in the order the DUT sees requests
	task automatic model_access(input address_t a, output logic h, output way_t w,
		output logic sv);
		tag_t   t;
		index_t s;
		logic   found;
		s     = index_t'(a >> `CACHE_OFFSET_BITS);
		t     = tag_t'(a >> (`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS));
		h     = 1'b0;
		w     = '0;
		found = 1'b0;
		sv    = |m_valid[s];
		for (int i = 0; i < `CACHE_WAYS; i++)
			if (m_valid[s][i] && m_tag[s][i] == t)
			begin
				h = 1'b1;
				w = way_t'(i);
			end
		if (!h)
		begin
			// Lowest empty way first and the set's pointer once all are taken
			for (int i = 0; i < `CACHE_WAYS; i++)
				if (!found && !m_valid[s][i])
				begin
					w     = way_t'(i);
					found = 1'b1;
				end
			if (!found)
				w = m_ptr[s];
			m_tag[s][w]   = t;
			m_valid[s][w] = 1'b1;
			m_ptr[s]      = m_ptr[s] + 2'd1;
		end
	endtask

	task automatic apply_request(input address_t a, input logic h, input way_t w,
		input logic sv);
		exp_hit_q.push_back(h);
		exp_way_q.push_back(w);
		exp_sv_q.push_back(sv);
		exp_step_q.push_back(step_no + 1);
		step_cycle(1'b1, a, 1'b0);
	endtask

	// Flush only once the pipe is empty so no fill shares its edge
	task automatic apply_flush();
		drain_results();
		step_cycle(1'b0, '0, 1'b1);
		for (int s = 0; s < `CACHE_LINES; s++)
			m_valid[s] = '0;
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		logic [31:0] rt;
		logic [31:0] rs;
		logic [31:0] ro;
		logic [31:0] r;
		address_t    a;
		logic        h;
		logic        sv;
		way_t        w;

		clk     = 1'b0;
		rst_n   = 1'b0;
		req     = 1'b0;
		adr     = '0;
		flush   = 1'b0;
		sv_due  = 1'b0;
		sv_exp  = 1'b0;
		stall   = 0;
		step_no = 0;
		lfsr    = 32'h8714;
		for (int s = 0; s < `CACHE_LINES; s++)
		begin
			m_valid[s] = '0;
			m_ptr[s]   = '0;
		end

		// Empty set misses into way 0 and the repeat hits
		add_entry(REQ, 22'h100, 6'd1, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h100, 6'd1, 4'h0, HIT, 2'd0, 1'b1);
		// Set 2 fills ways 0 to 3 and round-robin then takes ways 0, 1 and 2
		add_entry(REQ, 22'h201, 6'd2, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h202, 6'd2, 4'h0, MISS, 2'd1, 1'b1);
		add_entry(REQ, 22'h203, 6'd2, 4'h0, MISS, 2'd2, 1'b1);
		add_entry(REQ, 22'h204, 6'd2, 4'h0, MISS, 2'd3, 1'b1);
		add_entry(REQ, 22'h205, 6'd2, 4'h0, MISS, 2'd0, 1'b1);
		add_entry(REQ, 22'h206, 6'd2, 4'h0, MISS, 2'd1, 1'b1);
		add_entry(REQ, 22'h201, 6'd2, 4'h0, MISS, 2'd2, 1'b1);
		add_entry(REQ, 22'h204, 6'd2, 4'h0, HIT, 2'd3, 1'b1);
		// Offset bits do not matter but the set does
		add_entry(REQ, 22'h100, 6'd1, 4'hf, HIT, 2'd0, 1'b1);
		add_entry(REQ, 22'h100, 6'd1, 4'h8, HIT, 2'd0, 1'b1);
		add_entry(REQ, 22'h100, 6'd3, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h100, 6'd3, 4'h5, HIT, 2'd0, 1'b1);
		// After a flush everything misses and refills from way 0
		add_entry(FLUSH, '0, '0, '0, MISS, '0, 1'b0);
		add_entry(REQ, 22'h100, 6'd1, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h204, 6'd2, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h205, 6'd2, 4'h0, MISS, 2'd1, 1'b1);
		add_entry(REQ, 22'h100, 6'd1, 4'h0, HIT, 2'd0, 1'b1);
		// Back to back requests where a repeated miss address must hit
		add_entry(REQ, 22'h3aa, 6'd5, 4'h0, MISS, 2'd0, 1'b0);
		add_entry(REQ, 22'h3aa, 6'd5, 4'h0, HIT, 2'd0, 1'b1);
		add_entry(REQ, 22'h3ab, 6'd5, 4'h4, MISS, 2'd1, 1'b1);
		add_entry(REQ, 22'h3ab, 6'd5, 4'h4, HIT, 2'd1, 1'b1);

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("done", 32'(done), 32'd0);
		check_value("hit", 32'(hit), 32'd0);
		check_value("way", 32'(way), 32'd0);
		check_value("set_valid", 32'(set_valid), 32'd0);

		// Table rows go out one per cycle and also advance the model
		for (int i = 0; i < tbl_adr.size(); i++)
		begin
			if (tbl_flush[i])
				apply_flush();
			else
			begin
				model_access(tbl_adr[i], h, w, sv);
				apply_request(tbl_adr[i], tbl_hit[i], tbl_way[i], tbl_sv[i]);
			end
		end
		drain_results();

		// Eight tags over four sets keep hits and evictions frequent
		for (int n = 0; n < 300; n++)
		begin
			draw_bits(5, r);
			if (r == 0)
				apply_flush();
			draw_bits(2, r);
			if (r == 0)
				step_cycle(1'b0, '0, 1'b0);
			draw_bits(3, rt);
			draw_bits(2, rs);
			draw_bits(4, ro);
			a = make_adr(22'h40 | 22'(rt), 6'd8 | 6'(rs), 4'(ro));
			model_access(a, h, w, sv);
			apply_request(a, h, w, sv);
		end
		drain_results();

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== src/cache_addr_pkg.sv ====
// Address related types of the cache tag directory
// A request address splits into tag, set index and byte offset
// Modules name these types scoped in their ports and import the package inside

`include "cache_config.svh"

package cache_addr_pkg;

	// Full byte address as it arrives with a request
	typedef logic [`CACHE_AWID-1:0] address_t;

	// Tag bits sit above the index and offset fields
	typedef logic [`CACHE_AWID-`CACHE_INDEX_BITS-`CACHE_OFFSET_BITS-1:0] tag_t;

	// Set number taken from the middle of the address
	typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

	// Byte position inside a line
	// The directory ignores it but tests use it to walk one line
	typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;

endpackage

// ==== src/cache_config.svh ====
// Size settings for the 4-way set-associative tag directory
// Included by every package and RTL module of the directory
// The offset and index widths are derived from the line size and set count

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Width of a byte address on the request port
`define CACHE_AWID 32

// Number of sets held in each way
`define CACHE_LINES 64

// Number of ways per set
`define CACHE_WAYS 4

// Bytes in one cache line
`define CACHE_LINE_BYTES 16

// Low address bits that select a byte inside the line
`define CACHE_OFFSET_BITS $clog2(`CACHE_LINE_BYTES)

// Address bits above the offset that select the set
`define CACHE_INDEX_BITS $clog2(`CACHE_LINES)

`endif

// ==== src/cache_dir_top.sv ====
// Top level of the 4-way set-associative tag directory
// A req strobe with an address gives done with hit and way one cycle later,
// and set_valid one cycle after done
// A flush strobe clears all valid bits, req and flush never share a cycle

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_dir_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  cache_addr_pkg::address_t adr,
	input  logic                     flush,
	output logic                     done,
	output logic                     hit,
	output cache_way_pkg::way_t      way,
	output logic                     set_valid
);
	import cache_addr_pkg::*;
	import cache_way_pkg::*;

	// Read path between lookup and tag store
	index_t                   rd_index;
	tag_t [`CACHE_WAYS-1:0]   rd_tags;
	way_mask_t                rd_valid;

	// Fill path from lookup to tag store and victim select
	logic   fill_en;
	index_t fill_index;
	way_t   fill_way;
	tag_t   fill_tag;

	// Replacement choice for the set under lookup
	way_t victim_way;

	cache_tag_store u_tag_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.rd_index   (rd_index),
		.fill_en    (fill_en),
		.fill_index (fill_index),
		.fill_way   (fill_way),
		.fill_tag   (fill_tag),
		.rd_tags    (rd_tags),
		.rd_valid   (rd_valid)
	);

	cache_lookup u_lookup (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.adr        (adr),
		.rd_tags    (rd_tags),
		.rd_valid   (rd_valid),
		.victim_way (victim_way),
		.rd_index   (rd_index),
		.fill_en    (fill_en),
		.fill_index (fill_index),
		.fill_way   (fill_way),
		.fill_tag   (fill_tag),
		.done       (done),
		.hit        (hit),
		.way        (way),
		.set_valid  (set_valid)
	);

	// The read index is also the fill index, so the pointer that steps
	// belongs to the set being looked up
	cache_victim_select u_victim (
		.clk        (clk),
		.rst_n      (rst_n),
		.index      (rd_index),
		.valid      (rd_valid),
		.fill_en    (fill_en),
		.victim_way (victim_way)
	);

endmodule

// ==== src/cache_hit.sv ====
// Hit detector of the tag directory
// Compares one request tag against the four ways of a set
// Gives the hit flag and hit way in the same cycle, and the any-valid
// flag of the set two registers later

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_hit (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  cache_addr_pkg::tag_t                   req_tag,
	input  cache_addr_pkg::tag_t [`CACHE_WAYS-1:0] tags,
	input  cache_way_pkg::way_mask_t               valid,
	output logic                                   hit,
	output cache_way_pkg::way_t                    hit_way,
	output logic                                   set_valid
);
	import cache_way_pkg::*;

	// Per-way compare results
	way_mask_t match;

	// Way reported last time, held when nothing matches
	way_t prev_way;

	// First stage of the set-valid delay
	logic cv1;

	// A way matches only if its tag is equal and its entry is valid
	always_comb
	begin
		for (int i = 0; i < `CACHE_WAYS; i++)
			match[i] = valid[i] && (tags[i] == req_tag);
	end

	assign hit = |match;

	// Start from the held way so a miss leaves it unchanged
	// Scanning upward lets the highest matching way win
	always_comb
	begin
		hit_way = prev_way;
		for (int i = 0; i < `CACHE_WAYS; i++)
			if (match[i])
				hit_way = way_t'(i);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			prev_way <= '0;
		else
			prev_way <= hit_way;
	end

	// Any-valid flag of the looked-up set
	// Two registers place it one cycle behind the lookup result
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cv1       <= 1'b0;
			set_valid <= 1'b0;
		end
		else
		begin
			cv1       <= |valid;
			set_valid <= cv1;
		end
	end

endmodule

// ==== src/cache_lookup.sv ====
// Lookup stage of the tag directory
// Registers a request, splits the address and runs the hit check on the set
// A miss issues a fill of the victim way at the same edge that reports it
// done, hit and way come one cycle after the request is sampled

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_lookup (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   req,
	input  cache_addr_pkg::address_t               adr,
	input  cache_addr_pkg::tag_t [`CACHE_WAYS-1:0] rd_tags,
	input  cache_way_pkg::way_mask_t               rd_valid,
	input  cache_way_pkg::way_t                    victim_way,
	output cache_addr_pkg::index_t                 rd_index,
	output logic                                   fill_en,
	output cache_addr_pkg::index_t                 fill_index,
	output cache_way_pkg::way_t                    fill_way,
	output cache_addr_pkg::tag_t                   fill_tag,
	output logic                                   done,
	output logic                                   hit,
	output cache_way_pkg::way_t                    way,
	output logic                                   set_valid
);
	import cache_addr_pkg::*;
	import cache_way_pkg::*;

	// Registered request
	logic     req_q;
	address_t adr_q;

	// Fields of the registered address
	tag_t   tag_q;
	index_t index_q;

	// Result of the compare in the current cycle
	logic hit_c;
	way_t hit_way;

	// ============================================================
	// Request register
	// ============================================================

	// The address is reset too so the set read after reset is defined
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_q <= 1'b0;
			adr_q <= '0;
		end
		else
		begin
			req_q <= req;
			if (req)
				adr_q <= adr;
		end
	end

	// Tag above index, index above the line offset
	assign tag_q   = adr_q[`CACHE_AWID-1 : `CACHE_INDEX_BITS+`CACHE_OFFSET_BITS];
	assign index_q = adr_q[`CACHE_INDEX_BITS+`CACHE_OFFSET_BITS-1 : `CACHE_OFFSET_BITS];

	assign rd_index = index_q;

	// ============================================================
	// Hit check and fill
	// ============================================================

	cache_hit u_hit (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_tag   (tag_q),
		.tags      (rd_tags),
		.valid     (rd_valid),
		.hit       (hit_c),
		.hit_way   (hit_way),
		.set_valid (set_valid)
	);

	// A miss allocates right away, the tag store writes at the next edge
	// A request registered at that edge already sees the new entry
	assign fill_en    = req_q && !hit_c;
	assign fill_index = index_q;
	assign fill_way   = victim_way;
	assign fill_tag   = tag_q;

	// ============================================================
	// Result register
	// ============================================================

	// hit and way only change when a result is reported
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			done <= 1'b0;
			hit  <= 1'b0;
			way  <= '0;
		end
		else
		begin
			done <= req_q;
			if (req_q)
			begin
				hit <= hit_c;
				way <= hit_c ? hit_way : victim_way;
			end
		end
	end

endmodule

// ==== src/cache_tag_store.sv ====
// Tag and valid storage of the 4-way directory
// One tag array per way plus a valid bit per set and way
// Reads are combinational on rd_index, fills and flush act on the clock edge

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_store (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          flush,
	input  cache_addr_pkg::index_t                        rd_index,
	input  logic                                          fill_en,
	input  cache_addr_pkg::index_t                        fill_index,
	input  cache_way_pkg::way_t                           fill_way,
	input  cache_addr_pkg::tag_t                          fill_tag,
	output cache_addr_pkg::tag_t [`CACHE_WAYS-1:0]        rd_tags,
	output cache_way_pkg::way_mask_t                      rd_valid
);
	import cache_addr_pkg::*;
	import cache_way_pkg::*;

	// ============================================================
	// Storage
	// ============================================================

	// Tag memory indexed by way first and set second
	tag_t tag_mem [`CACHE_WAYS][`CACHE_LINES];

	// Valid bits kept as one mask per set so a read returns all ways at once
	way_mask_t valid_q [`CACHE_LINES];

	// ============================================================
	// Write side
	// ============================================================

	// A fill writes exactly one tag in the selected way and set
	// Tags stay stale after a flush since the valid bit qualifies them
	always_ff @(posedge clk)
	begin
		if (fill_en)
			tag_mem[fill_way][fill_index] <= fill_tag;
	end

	// Valid bits are control state and clear on reset
	// A flush wins over a fill at the same edge, the request came first
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `CACHE_LINES; s++)
				valid_q[s] <= '0;
		end
		else if (flush)
		begin
			for (int s = 0; s < `CACHE_LINES; s++)
				valid_q[s] <= '0;
		end
		else if (fill_en)
		begin
			valid_q[fill_index][fill_way] <= 1'b1;
		end
	end

	// ============================================================
	// Read side
	// ============================================================

	// All four tags of the set come out together for the parallel compare
	always_comb
	begin
		for (int w = 0; w < `CACHE_WAYS; w++)
			rd_tags[w] = tag_mem[w][rd_index];
	end

	// Valid mask of the same set
	assign rd_valid = valid_q[rd_index];

endmodule

// ==== src/cache_victim_select.sv ====
// Replacement choice for the 4-way directory
// Picks the lowest invalid way of a set, or the set's round-robin
// pointer when every way is valid
// The pointer of a set steps on each fill of that set

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_victim_select (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_addr_pkg::index_t   index,
	input  cache_way_pkg::way_mask_t valid,
	input  logic                     fill_en,
	output cache_way_pkg::way_t      victim_way
);
	import cache_way_pkg::*;

	// ============================================================
	// Round-robin pointers
	// ============================================================

	// One pointer per set, all start at way 0
	way_t ptr_q [`CACHE_LINES];

	// Every fill advances the pointer, including fills into an empty way
	// The two-bit pointer wraps from way 3 back to way 0 on its own
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < `CACHE_LINES; s++)
				ptr_q[s] <= '0;
		end
		else if (fill_en)
		begin
			ptr_q[index] <= ptr_q[index] + 1'b1;
		end
	end

	// ============================================================
	// Victim choice
	// ============================================================

	// Default to the pointer, which is only kept when the set is full
	// A downward scan leaves the lowest invalid way as the final choice
	always_comb
	begin
		victim_way = ptr_q[index];
		for (int i = `CACHE_WAYS - 1; i >= 0; i--)
			if (!valid[i])
				victim_way = way_t'(i);
	end

endmodule

// ==== src/cache_way_pkg.sv ====
// Way related types of the cache tag directory
// Holds the way number and the one-bit-per-way mask
// Valid bits and compare results both travel as a way mask

`include "cache_config.svh"

package cache_way_pkg;

	// Way number, two bits for four ways
	typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

	// One bit per way, bit n belongs to way n
	typedef logic [`CACHE_WAYS-1:0] way_mask_t;

endpackage

// ==== tb.f ====
+incdir+src
src/cache_addr_pkg.sv
src/cache_way_pkg.sv
src/cache_tag_store.sv
src/cache_hit.sv
src/cache_victim_select.sv
src/cache_lookup.sv
src/cache_dir_top.sv
sim/cache_tb.sv
